// ==== rtl/busPkg.sv ====
//**************************************************
// Shared bus types, strobe bundles, ALU op codes.
//**************************************************
package busPkg;

    localparam int WordWidth   = 32;   // Bus and register width.
    localparam int SourceCount = 24;   // Real bus sources, constant included.
    localparam int GprCount    = 16;   // General registers R0..R15.

    typedef logic [WordWidth-1:0] word_t;    // One bus word.
    typedef logic [4:0]           selCode_t; // Bus select code.
    typedef logic [18:0]          cField_t;  // Instruction constant field.
    typedef logic [4:0]           shAmt_t;   // Shift distance from operand B.

    // Select codes above the general registers.
    localparam selCode_t CodeHi      = 5'd16;
    localparam selCode_t CodeLo      = 5'd17;
    localparam selCode_t CodeZHigh   = 5'd18;
    localparam selCode_t CodeZLow    = 5'd19;
    localparam selCode_t CodePc      = 5'd20;
    localparam selCode_t CodeMdr     = 5'd21;
    localparam selCode_t CodeInPort  = 5'd22;
    localparam selCode_t CodeC       = 5'd23;
    localparam selCode_t NoDriveCode = 5'd31; // Bus idle, carries zero.

    // Registered source words, 23 in all.
    typedef struct packed {
        word_t [GprCount-1:0] gpr;
        word_t hi;
        word_t lo;
        word_t zHigh;
        word_t zLow;
        word_t pc;
        word_t mdr;
        word_t inPort;
    } busSources_t;

    // One drive strobe per source.
    typedef struct packed {
        logic [GprCount-1:0] gprOut;
        logic hiOut;
        logic loOut;
        logic zHighOut;
        logic zLowOut;
        logic pcOut;
        logic mdrOut;
        logic inPortOut;
        logic cOut;
    } busDrive_t;

    // Register bank load strobes.
    typedef struct packed {
        logic [GprCount-1:0] gprIn;
        logic hiIn;
        logic loIn;
        logic pcIn;
        logic mdrIn;
        logic inPortIn;
        logic outPortIn;
    } regLoad_t;

    typedef enum logic [3:0] {
        opAdd = 4'd0,
        opSub = 4'd1,
        opAnd = 4'd2,
        opOr  = 4'd3,
        opShl = 4'd4,
        opShr = 4'd5,
        opNeg = 4'd6,
        opNot = 4'd7
    } aluOp_t;

    typedef struct packed {
        aluOp_t op;
        logic   yIn;   // Load Y from bus.
        logic   zIn;   // Load Z from ALU result.
    } aluCtrl_t;

endpackage

// ==== rtl/busEncoder.sv ====
//**************************************************
// Priority encoder, drive strobes to bus select code.
//**************************************************
module busEncoder (
    input  busPkg::busDrive_t drive,
    output busPkg::selCode_t  selCode
);
    import busPkg::*;

    logic [SourceCount-1:0] strobeVec; // Strobes indexed by select code.

    // Bit position equals the select code of that source.
    assign strobeVec = {
        drive.cOut,       // 23
        drive.inPortOut,  // 22
        drive.mdrOut,     // 21
        drive.pcOut,      // 20
        drive.zLowOut,    // 19
        drive.zHighOut,   // 18
        drive.loOut,      // 17
        drive.hiOut,      // 16
        drive.gprOut      // 15..0
    };

    // Walk downward so the lowest active code is written last and wins.
    always_comb begin
        selCode = NoDriveCode; // Nothing driven.
        for (int i = SourceCount - 1; i >= 0; i--) begin
            if (strobeVec[i]) begin
                selCode = selCode_t'(i);
            end
        end
    end

endmodule

// ==== rtl/busMux.sv ====
//**************************************************
// 32-to-1 bus multiplexer with constant sign extension.
//**************************************************
module busMux (
    input  busPkg::busSources_t sources,
    input  busPkg::cField_t     cField,
    input  busPkg::selCode_t    selCode,
    output busPkg::word_t       busValue
);
    import busPkg::*;

    localparam int CWidth   = $bits(cField_t);
    localparam int ExtWidth = WordWidth - CWidth;

    word_t cExtended; // Constant field widened to a bus word.

    // Replicate the top bit of C over the upper part.
    assign cExtended = {{ExtWidth{cField[CWidth-1]}}, cField};

    //**************************************************
    // Source select
    //**************************************************
    always_comb begin
        busValue = '0; // Codes 24..31, idle bus.
        if (selCode < CodeHi) begin
            busValue = sources.gpr[selCode[3:0]]; // R0..R15.
        end else begin
            case (selCode)
                CodeHi: begin
                    busValue = sources.hi;
                end
                CodeLo: begin
                    busValue = sources.lo;
                end
                CodeZHigh: begin
                    busValue = sources.zHigh;
                end
                CodeZLow: begin
                    busValue = sources.zLow;
                end
                CodePc: begin
                    busValue = sources.pc;
                end
                CodeMdr: begin
                    busValue = sources.mdr;
                end
                CodeInPort: begin
                    busValue = sources.inPort;
                end
                CodeC: begin
                    busValue = cExtended;
                end
                default: begin
                    busValue = '0; // Unused codes read as zero.
                end
            endcase
        end
    end

endmodule

// ==== rtl/regBank.sv ====
//**************************************************
// General registers, HI, LO, PC, MDR and I/O ports.
// Packs all register words into the bus source bundle.
//**************************************************
module regBank (
    input  logic                clk,
    input  logic                rstN,
    input  busPkg::regLoad_t    load,
    input  busPkg::word_t       busValue,
    input  busPkg::word_t       inPortData,
    input  busPkg::word_t       zHigh,
    input  busPkg::word_t       zLow,
    output busPkg::busSources_t sources,
    output busPkg::word_t       outPort
);
    import busPkg::*;

    word_t [GprCount-1:0] gprReg; // R0..R15.
    word_t hiReg;                  // Upper product or remainder.
    word_t loReg;                  // Lower product or quotient.
    word_t pcReg;                  // Program counter.
    word_t mdrReg;                 // Memory data register.
    word_t inPortReg;              // Captured input port.
    word_t outPortReg;             // Output port latch.

    //**************************************************
    // General registers
    //**************************************************
    // Any number of gprIn bits may be high, all take the same bus word.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            gprReg <= '0;
        end else begin
            for (int i = 0; i < GprCount; i++) begin
                if (load.gprIn[i]) begin
                    gprReg[i] <= busValue;
                end
            end
        end
    end

    //**************************************************
    // Special registers
    //**************************************************
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            hiReg  <= '0;
            loReg  <= '0;
            pcReg  <= '0;
            mdrReg <= '0;
        end else begin
            if (load.hiIn) begin
                hiReg <= busValue;
            end
            if (load.loIn) begin
                loReg <= busValue;
            end
            if (load.pcIn) begin
                pcReg <= busValue;
            end
            if (load.mdrIn) begin
                mdrReg <= busValue; // No memory side, bus only.
            end
        end
    end

    // Input port samples the pins, not the bus.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            inPortReg <= '0;
        end else if (load.inPortIn) begin
            inPortReg <= inPortData;
        end
    end

    // Output port holds its word until the next outPortIn.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outPortReg <= '0;
        end else if (load.outPortIn) begin
            outPortReg <= busValue;
        end
    end

    //**************************************************
    // Source bundle
    //**************************************************
    assign sources.gpr    = gprReg;
    assign sources.hi     = hiReg;
    assign sources.lo     = loReg;
    assign sources.zHigh  = zHigh;     // Z lives in the ALU.
    assign sources.zLow   = zLow;
    assign sources.pc     = pcReg;
    assign sources.mdr    = mdrReg;
    assign sources.inPort = inPortReg;

    assign outPort = outPortReg;

endmodule

// ==== rtl/aluUnit.sv ====
//**************************************************
// ALU with Y operand register and 64-bit Z result.
//**************************************************
module aluUnit (
    input  logic             clk,
    input  logic             rstN,
    input  busPkg::aluCtrl_t ctrl,
    input  busPkg::word_t    busValue,
    output busPkg::word_t    zHigh,
    output busPkg::word_t    zLow
);
    import busPkg::*;

    word_t                  yReg;     // Operand A.
    logic [2*WordWidth-1:0] zReg;     // Result, high half on top.
    word_t                  resHigh;  // Next Z high.
    word_t                  resLow;   // Next Z low.
    logic [WordWidth:0]     sumExt;   // Sum with carry bit.
    logic [WordWidth:0]     diffExt;  // Difference with borrow bit.
    logic [2*WordWidth-1:0] shlExt;   // Left shift, spill in upper half.
    shAmt_t                 shAmt;

    //**************************************************
    // Operand register
    //**************************************************
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            yReg <= '0;
        end else if (ctrl.yIn) begin
            yReg <= busValue;
        end
    end

    // Arithmetic in one extra bit so carry and borrow fall out.
    assign sumExt  = {1'b0, yReg} + {1'b0, busValue};
    assign diffExt = {1'b0, yReg} - {1'b0, busValue};
    assign shAmt   = busValue[$bits(shAmt_t)-1:0]; // Low 5 bits of B.
    assign shlExt  = {{WordWidth{1'b0}}, yReg} << shAmt;

    //**************************************************
    // Operation select
    //**************************************************
    always_comb begin
        resHigh = '0; // Most ops leave Z high clear.
        resLow  = '0;
        case (ctrl.op)
            opAdd: begin
                resLow  = sumExt[WordWidth-1:0];
                resHigh = word_t'(sumExt[WordWidth]); // Carry out.
            end
            opSub: begin
                resLow  = diffExt[WordWidth-1:0];
                resHigh = word_t'(diffExt[WordWidth]); // Borrow.
            end
            opAnd: begin
                resLow = yReg & busValue;
            end
            opOr: begin
                resLow = yReg | busValue;
            end
            opShl: begin
                resLow  = shlExt[WordWidth-1:0];
                resHigh = shlExt[2*WordWidth-1:WordWidth]; // Bits pushed out.
            end
            opShr: begin
                resLow = yReg >> shAmt; // Logical, zero fill.
            end
            opNeg: begin
                resLow = -busValue;
            end
            opNot: begin
                resLow = ~busValue;
            end
            default: begin
                resLow = '0;
            end
        endcase
    end

    //**************************************************
    // Result register
    //**************************************************
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            zReg <= '0;
        end else if (ctrl.zIn) begin
            zReg <= {resHigh, resLow};
        end
    end

    assign zHigh = zReg[2*WordWidth-1:WordWidth];
    assign zLow  = zReg[WordWidth-1:0];

endmodule

// ==== rtl/datapathTop.sv ====
//**************************************************
// Single-bus datapath: registers, bus and ALU.
//**************************************************
module datapathTop (
    input  logic              clk,
    input  logic              rstN,
    input  busPkg::busDrive_t drive,
    input  busPkg::regLoad_t  load,
    input  busPkg::aluCtrl_t  aluCtrl,
    input  busPkg::cField_t   cField,
    input  busPkg::word_t     inPortData,
    output busPkg::word_t     busValue,
    output busPkg::word_t     outPort
);
    import busPkg::*;

    busSources_t sources;  // All registered bus sources.
    selCode_t    selCode;  // Winning drive strobe.
    word_t       zHigh;    // Z halves, back into the source bundle.
    word_t       zLow;

    //**************************************************
    // Sources and sinks
    //**************************************************
    regBank i_regBank (
        .clk        (clk),
        .rstN       (rstN),
        .load       (load),
        .busValue   (busValue),
        .inPortData (inPortData),
        .zHigh      (zHigh),
        .zLow       (zLow),
        .sources    (sources),
        .outPort    (outPort)
    );

    //**************************************************
    // Shared bus
    //**************************************************
    busEncoder i_busEncoder (
        .drive   (drive),
        .selCode (selCode)
    );

    busMux i_busMux (
        .sources  (sources),
        .cField   (cField),
        .selCode  (selCode),
        .busValue (busValue)  // Also the top-level bus port.
    );

    // ALU reads the same bus word the registers see.
    aluUnit i_aluUnit (
        .clk      (clk),
        .rstN     (rstN),
        .ctrl     (aluCtrl),
        .busValue (busValue),
        .zHigh    (zHigh),
        .zLow     (zLow)
    );

endmodule

// ==== dv/datapathTb.sv ====
//**************************************************
// Testbench for the single-bus datapath, driven from a step file.
//**************************************************
module datapathTb;
    import busPkg::*;

    localparam int          ClkPeriod   = 20;
    localparam int          HalfPeriod  = ClkPeriod / 2;
    localparam int          ResetCycles = 8;
    localparam int          FieldCount  = 8;   // Words per step in the file.
    localparam int          MaxSteps    = 64;
    localparam logic [31:0] EndMarker   = 32'hFFFF_FFFF; // Drive column of the last line.

    logic      clk;
    logic      rstN;
    busDrive_t drive;
    regLoad_t  load;
    aluCtrl_t  aluCtrl;
    cField_t   cField;
    word_t     inPortData;
    word_t     busValue;
    word_t     outPort;

    logic [31:0] stimMem [0:MaxSteps*FieldCount-1]; // Raw step words.
    int          stepCount;
    logic        stimReady;                         // Step count known.
    int          busErrors;
    int          outErrors;
    int          otherErrors;

    datapathTop i_dut (
        .clk        (clk),
        .rstN       (rstN),
        .drive      (drive),
        .load       (load),
        .aluCtrl    (aluCtrl),
        .cField     (cField),
        .inPortData (inPortData),
        .busValue   (busValue),
        .outPort    (outPort)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #HalfPeriod clk = ~clk;
        end
    end

    //**************************************************
    // Compare tasks
    //**************************************************
    task automatic checkBus(input word_t got, input word_t exp, input int step);
        if (got !== exp) begin
            $display("MISMATCH step %0d busValue got 0x%08h expected 0x%08h", step, got, exp);
            busErrors++;
        end
    endtask

    task automatic checkOutPort(input word_t got, input word_t exp, input int step);
        if (got !== exp) begin
            $display("MISMATCH step %0d outPort got 0x%08h expected 0x%08h", step, got, exp);
            outErrors++;
        end
    endtask

    // Unpack one line of the file onto the DUT inputs.
    task automatic applyStep(input int step);
        int base;
        base        = step * FieldCount;
        drive       = stimMem[base][23:0];
        load        = stimMem[base + 1][21:0];
        aluCtrl.op  = aluOp_t'(stimMem[base + 2][5:2]);
        aluCtrl.yIn = stimMem[base + 2][1];
        aluCtrl.zIn = stimMem[base + 2][0];
        cField      = stimMem[base + 3][18:0];
        inPortData  = stimMem[base + 4];
    endtask

    //**************************************************
    // Main sequence
    //**************************************************
    initial begin
        int base;
        rstN        = 1'b0;
        drive       = '0;
        load        = '0;
        aluCtrl     = '0;
        cField      = '0;
        inPortData  = '0;
        busErrors   = 0;
        outErrors   = 0;
        otherErrors = 0;
        stimReady   = 1'b0;

        $readmemh("dv/datapathStim.mem", stimMem);
        stepCount = 0;
        while (stepCount < MaxSteps && stimMem[stepCount * FieldCount] !== EndMarker) begin
            stepCount++;
        end
        if (stepCount == 0 || stepCount == MaxSteps) begin
            $display("ERROR: stimulus file is missing, empty or has no end marker");
            otherErrors++;
            stepCount = 0; // Run nothing.
        end
        stimReady = 1'b1;

        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        for (int step = 0; step < stepCount; step++) begin
            @(negedge clk);
            applyStep(step);
            #(HalfPeriod - 2);             // Settled, edge still ahead.
            base = step * FieldCount;
            checkBus(busValue, stimMem[base + 5], step);
            if (stimMem[base + 7][0]) begin
                checkOutPort(outPort, stimMem[base + 6], step);
            end
        end

        $display("Errors: busValue %0d, outPort %0d, other %0d",
                 busErrors, outErrors, otherErrors);
        if (busErrors + outErrors + otherErrors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    //**************************************************
    // Watchdog
    //**************************************************
    initial begin
        wait (stimReady);
        #((ResetCycles + stepCount + 10) * ClkPeriod); // Whole run plus margin.
        $display("ERROR: simulation timed out before all steps finished");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== dv/datapathStim.mem ====
// One datapath step per line, hex: drive load aluCtrl cField inPort expBus expOut checkOut
// aluCtrl is op*4 + yIn*2 + zIn. A drive word of FFFFFFFF ends the list.
// Reset state.
000000 000000 00 00000 00000000 00000000 00000000 1 // Idle bus, outPort clear.
000100 000000 00 00000 00000000 00000000 00000000 0 // R0.
800000 000000 00 00000 00000000 00000000 00000000 0 // R15.
000008 000000 00 00000 00000000 00000000 00000000 0 // PC.
000004 000000 00 00000 00000000 00000000 00000000 0 // MDR.
// Input port into several registers.
000000 000002 00 00000 A5C31E07 00000000 00000000 0 // Capture pins.
000002 00818C 00 00000 00000000 A5C31E07 00000000 0 // Into R1 R2 R9 PC MDR.
000200 000000 00 00000 00000000 A5C31E07 00000000 0
000400 000000 00 00000 00000000 A5C31E07 00000000 0
020000 000000 00 00000 00000000 A5C31E07 00000000 0
000008 000000 00 00000 00000000 A5C31E07 00000000 0
000004 000000 00 00000 00000000 A5C31E07 00000000 0
// Constant, positive then negative field.
000001 000200 00 12345 00000000 00012345 00000000 0 // Also into R3.
000001 000000 00 4ABCD 00000000 FFFCABCD 00000000 0
// Priority and empty bus.
020800 000000 00 00000 00000000 00012345 00000000 0 // R3 beats R9.
000009 000000 00 12345 00000000 A5C31E07 00000000 0 // PC beats C.
000000 000000 00 4ABCD 00000000 00000000 00000000 0
// ALU, Y is A5C31E07 throughout.
000200 000000 02 00000 00000000 A5C31E07 00000000 0 // Load Y.
000001 000000 01 4ABCD 00000000 FFFCABCD 00000000 0 // Add.
000010 000000 00 00000 00000000 A5BFC9D4 00000000 0
000020 000000 00 00000 00000000 00000001 00000000 0 // Carry.
000001 000000 05 7FFFF 00000000 FFFFFFFF 00000000 0 // Sub.
000010 000000 00 00000 00000000 A5C31E08 00000000 0
000020 000000 00 00000 00000000 00000001 00000000 0 // Borrow.
000800 000000 09 00000 00000000 00012345 00000000 0 // And with R3.
000010 000000 00 00000 00000000 00010205 00000000 0
000020 000000 00 00000 00000000 00000000 00000000 0
000001 000000 0D 12345 00000000 00012345 00000000 0 // Or.
000010 000000 00 00000 00000000 A5C33F47 00000000 0
000020 000000 00 00000 00000000 00000000 00000000 0
000001 000000 11 00128 00000000 00000128 00000000 0 // Shl by 8.
000010 000000 00 00000 00000000 C31E0700 00000000 0
000020 000000 00 00000 00000000 000000A5 00000000 0 // Spilled bits.
000001 000000 15 00024 00000000 00000024 00000000 0 // Shr by 4.
000010 000000 00 00000 00000000 0A5C31E0 00000000 0
000020 000000 00 00000 00000000 00000000 00000000 0
000800 000000 19 00000 00000000 00012345 00000000 0 // Neg of R3.
000010 000000 00 00000 00000000 FFFEDCBB 00000000 0
000020 000000 00 00000 00000000 00000000 00000000 0
000001 000000 1D 4ABCD 00000000 FFFCABCD 00000000 0 // Not.
000010 000030 00 00000 00000000 00035432 00000000 0 // Zlow into LO and HI.
000020 000000 00 00000 00000000 00000000 00000000 0
// Output port holds while the bus moves on.
000080 000001 00 00000 00000000 00035432 00000000 1 // HI to outPort.
000040 000000 00 00000 00000000 00035432 00035432 1
000001 000000 00 7FFFF 00000000 FFFFFFFF 00035432 1
000200 000000 00 00000 00000000 A5C31E07 00035432 1
000000 000000 00 00000 00000000 00000000 00035432 1
FFFFFFFF // End of steps.

// ==== verilog.f ====
rtl/busPkg.sv
rtl/busEncoder.sv
rtl/busMux.sv
rtl/regBank.sv
rtl/aluUnit.sv
rtl/datapathTop.sv
dv/datapathTb.sv
